/* vlog.f */
+incdir+sim
logic/fxp_pkg.sv
logic/stream_pkg.sv
logic/fxp_resize.sv
logic/op_queue.sv
logic/fxp_arith_pipe.sv
logic/fxp_alu_top.sv
sim/fxp_alu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the Q8.8 ALU testbench with Verilator, run it, and check the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module fxp_alu_tb \
    -o fxp_alu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/fxp_alu_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

cat sim.log

if grep -q "^Done: no errors$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* sim/fxp_model.svh */
// --------------------
// Reference arithmetic for the testbench, worked out in plain integers.
// Include inside a module that imports fxp_pkg and stream_pkg.
// --------------------
`ifndef FXP_MODEL_SVH
`define FXP_MODEL_SVH

// value counted in Q8.8 steps, clamped to the format range
function automatic op_rsp_t clamp_to_range(input longint value);
    op_rsp_t r;
    r.overflow = 1'b0;
    r.result   = fxp_t'(value);
    if (value > longint'(FXP_MAX)) begin
        r.overflow = 1'b1;
        r.result   = FXP_MAX;
    end else if (value < longint'(FXP_MIN)) begin
        r.overflow = 1'b1;
        r.result   = FXP_MIN;
    end
    return r;
endfunction

// Q16.16 value down to Q8.8, round half up, then saturate
function automatic op_rsp_t model_resize(input longint wide);
    longint kept;
    longint top;
    kept = wide >>> FRAC_BITS;
    top  = (longint'(1) <<< (PROD_WIDTH - FRAC_BITS - 1)) - 1;
    if (wide[FRAC_BITS-1] && kept != top) begin
        kept = kept + 1;
    end
    return clamp_to_range(kept);
endfunction

// sums and differences are exact in Q8.8 steps and need no rounding
function automatic op_rsp_t model_op(input alu_op_e op, input fxp_t a, input fxp_t b);
    case (op)
        OP_ADD:  return clamp_to_range(longint'(a) + longint'(b));
        OP_SUB:  return clamp_to_range(longint'(a) - longint'(b));
        OP_MUL:  return model_resize(longint'(a) * longint'(b));
        default: return '0;
    endcase
endfunction

`endif

/* sim/fxp_alu_tb.sv */
// --------------------
// Random add/sub/mul traffic under credits on both sides of the ALU.
// --------------------
`timescale 1ns/1ns

module fxp_alu_tb;
    import fxp_pkg::*;
    import stream_pkg::*;

    `include "fxp_model.svh"

    localparam int BURST_REQS  = 20;
    localparam int TOTAL_REQS  = 200 + 200 + 300 + BURST_REQS + QUEUE_DEPTH;
    localparam int CYCLE_LIMIT = 4 * TOTAL_REQS + 200;

    logic    clk;
    logic    rst;
    logic    in_valid;
    op_req_t in_req;
    logic    in_credit;
    logic    out_credit;
    logic    out_valid;
    op_rsp_t out_rsp;

    integer  seed = 10551;
    op_req_t req_q[$];
    op_rsp_t exp_q[$];
    op_rsp_t want;
    int      errors = 0;
    int      tests = 0;
    int      cycle = 0;
    int      send_credits = QUEUE_DEPTH;
    int      sent_total = 0;
    int      in_credit_count = 0;
    int      out_valid_count = 0;
    int      granted = OUT_CREDITS;
    int      sink_pending = 0;
    logic    sink_stall = 1'b0;

    fxp_alu_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_rsp    (out_rsp)
    );

    always #20 clk = ~clk;

    // --------------------
    // sender, sink, monitor
    // --------------------

    always @(posedge clk) begin
        #2;
        in_valid   = 1'b0;
        out_credit = 1'b0;
        if (!rst) begin
            if (req_q.size() > 0 && send_credits > 0) begin
                in_req       = req_q.pop_front();
                in_valid     = 1'b1;
                send_credits = send_credits - 1;
                sent_total   = sent_total + 1;
            end
            // sink frees a slot now and then
            if (!sink_stall && sink_pending > 0 && ($random(seed) & 1) == 1) begin
                out_credit   = 1'b1;
                sink_pending = sink_pending - 1;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (in_credit) begin
                in_credit_count = in_credit_count + 1;
                send_credits    = send_credits + 1;
            end
            if (out_credit) begin
                granted = granted + 1;
            end
            if (out_valid) begin
                out_valid_count = out_valid_count + 1;
                sink_pending    = sink_pending + 1;
                if (out_valid_count > granted) begin
                    $display("result %0d sent with only %0d sink slots granted",
                             out_valid_count, granted);
                    errors = errors + 1;
                end
                if (exp_q.size() == 0) begin
                    $display("result arrived with no request outstanding");
                    errors = errors + 1;
                end else begin
                    want = exp_q.pop_front();
                    check_value("out_rsp.result", 32'(out_rsp.result), 32'(want.result));
                    check_value("out_rsp.overflow", 32'(out_rsp.overflow), 32'(want.overflow));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d results still missing", cycle, exp_q.size());
            $display("Done: errors found");
            $finish;
        end
    end

    // --------------------
    // helpers
    // --------------------

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    // mostly random, sometimes close to either limit
    function automatic fxp_t pick_operand();
        logic [2:0] kind;
        fxp_t       near;
        kind = 3'($random(seed));
        near = fxp_t'($random(seed) & 32'h3ff);
        case (kind)
            3'd0:    return FXP_MAX - near;
            3'd1:    return FXP_MIN + near;
            default: return fxp_t'($random(seed));
        endcase
    endfunction

    task automatic queue_request(input op_req_t req);
        req_q.push_back(req);
        exp_q.push_back(model_op(req.op, req.a, req.b));
    endtask

    task automatic drain_all();
        while (exp_q.size() != 0 || req_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic report_test(input string name, input int err_mark);
        tests = tests + 1;
        $display("test %s finished, %0d errors", name, errors - err_mark);
    endtask

    task automatic run_ops(input string name, input alu_op_e op, input int count);
        int      err_mark;
        op_req_t req;
        err_mark = errors;
        for (int i = 0; i < count; i++) begin
            req.op = op;
            req.a  = pick_operand();
            req.b  = pick_operand();
            if (i == 0) begin
                // corner case that must saturate
                req.a = (op == OP_ADD) ? FXP_MAX : FXP_MIN;
                req.b = (op == OP_SUB) ? fxp_t'(16'h0100) : req.a;
            end
            queue_request(req);
        end
        drain_all();
        report_test(name, err_mark);
    endtask

    // --------------------
    // test sequence
    // --------------------

    initial begin
        int      err_mark;
        int      cred_mark;
        int      sent_mark;
        op_req_t req;
        clk        = 1'b0;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_req     = '0;
        out_credit = 1'b0;
        repeat (8) @(posedge clk);
        #2 rst = 1'b0;

        err_mark = errors;
        repeat (10) begin
            @(negedge clk);
            check_value("out_valid", 32'(out_valid), 32'd0);
            check_value("in_credit", 32'(in_credit), 32'd0);
        end
        report_test("idle", err_mark);

        run_ops("add", OP_ADD, 200);
        run_ops("sub", OP_SUB, 200);
        run_ops("mul", OP_MUL, 300);

        // sink holds every slot back for a while
        err_mark   = errors;
        sink_stall = 1'b1;
        for (int i = 0; i < BURST_REQS; i++) begin
            req.op = alu_op_e'(2'($unsigned($random(seed)) % 3));
            req.a  = pick_operand();
            req.b  = pick_operand();
            queue_request(req);
        end
        repeat (50) @(posedge clk);
        sink_stall = 1'b0;
        drain_all();
        report_test("output credits", err_mark);

        err_mark   = errors;
        cred_mark  = in_credit_count;
        sent_mark  = sent_total;
        sink_stall = 1'b1;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            req.op = OP_MUL;
            req.a  = pick_operand();
            req.b  = pick_operand();
            queue_request(req);
        end
        repeat (20) @(posedge clk);
        sink_stall = 1'b0;
        drain_all();
        repeat (4) @(negedge clk);
        check_value("in_credit pulses", 32'(in_credit_count - cred_mark),
                    32'(sent_total - sent_mark));
        report_test("input credits", err_mark);

        $display("%0d tests, %0d requests, %0d errors", tests, sent_total, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* logic/fxp_alu_top.sv */
// --------------------
// Q8.8 add/sub/mul unit with credit flow control on both sides.
// out_credit pulses must never return more slots than were granted.
// --------------------
`timescale 1ns/1ns

module fxp_alu_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  stream_pkg::op_req_t in_req,
    output logic                in_credit,
    input  logic                out_credit,
    output logic                out_valid,
    output stream_pkg::op_rsp_t out_rsp
);
    import stream_pkg::*;

    op_req_t           head;
    logic              not_empty;
    logic              pop;
    logic [OCNT_W-1:0] out_cnt;

    // --------------------
    // issue decision
    // --------------------

    // each issue claims a sink slot up front, so the pipe never has to stall
    assign pop = not_empty && (out_cnt != '0);

    // free sink slots; an issue and a returned credit in one cycle cancel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_cnt <= OCNT_W'(OUT_CREDITS);
        end else begin
            case ({pop, out_credit})
                2'b10:   out_cnt <= out_cnt - 1'b1;
                2'b01:   out_cnt <= out_cnt + 1'b1;
                default: out_cnt <= out_cnt;
            endcase
        end
    end

    // --------------------
    // instances
    // --------------------

    op_queue u_queue (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .in_credit (in_credit)
    );

    // results leave in issue order, which is request order
    fxp_arith_pipe u_pipe (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (pop),
        .issue_req   (head),
        .rsp_valid   (out_valid),
        .rsp         (out_rsp)
    );

endmodule

/* logic/fxp_arith_pipe.sv */
// --------------------
// Two stages, no stall. rsp_valid follows issue_valid by two edges,
// so the caller must hold a sink slot for every issue.
// --------------------
`timescale 1ns/1ns

module fxp_arith_pipe (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue_valid,
    input  stream_pkg::op_req_t issue_req,
    output logic                rsp_valid,
    output stream_pkg::op_rsp_t rsp
);
    import fxp_pkg::*;
    import stream_pkg::*;

    logic signed [PROD_WIDTH-1:0] a_ext;
    logic signed [PROD_WIDTH-1:0] b_ext;
    logic signed [PROD_WIDTH-1:0] exact;
    logic                         s1_valid;
    logic [PROD_WIDTH-1:0]        s1_wide;
    fxp_t                         res_val;
    logic                         res_ovf;

    // --------------------
    // stage 1, exact Q16.16 result
    // --------------------

    // operands widened to Q24.8 so sums cannot wrap
    assign a_ext = {{(PROD_WIDTH-FXP_WIDTH){issue_req.a[FXP_WIDTH-1]}}, issue_req.a};
    assign b_ext = {{(PROD_WIDTH-FXP_WIDTH){issue_req.b[FXP_WIDTH-1]}}, issue_req.b};

    always_comb begin
        case (issue_req.op)
            // sums are moved up to Q16.16 so one resize serves all ops
            OP_ADD:  exact = (a_ext + b_ext) <<< FRAC_BITS;
            OP_SUB:  exact = (a_ext - b_ext) <<< FRAC_BITS;
            // Q8.8 times Q8.8 already lands in Q16.16
            OP_MUL:  exact = a_ext * b_ext;
            default: exact = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            s1_wide <= exact;
        end
    end

    // --------------------
    // stage 2, resize and output
    // --------------------

    fxp_resize u_resize (
        .wide     (s1_wide),
        .result   (res_val),
        .overflow (res_ovf)
    );

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            rsp <= '{result: res_val, overflow: res_ovf};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            s1_valid  <= issue_valid;
            rsp_valid <= s1_valid;
        end
    end

endmodule

/* logic/op_queue.sv */
// --------------------
// Request FIFO fed under credits. A sender that spends more credits
// than it holds overwrites live entries; nothing here guards it.
// --------------------
`timescale 1ns/1ns

module op_queue (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  stream_pkg::op_req_t in_req,
    input  logic                pop,
    output stream_pkg::op_req_t head,
    output logic                not_empty,
    output logic                in_credit
);
    import stream_pkg::*;

    op_req_t           mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QCNT_W-1:0] count;

    // --------------------
    // storage
    // --------------------

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_req;
        end
    end

    // head reads straight from the array, so a write shows up one edge later
    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

    // --------------------
    // pointers and occupancy
    // --------------------

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // one credit back per freed entry
            in_credit <= pop;
        end
    end

endmodule

/* logic/fxp_resize.sv */
// --------------------
// Q16.16 in, Q8.8 out. Rounds half up on the first dropped bit,
// then saturates and flags overflow.
// --------------------
`timescale 1ns/1ns

module fxp_resize (
    input  logic [fxp_pkg::PROD_WIDTH-1:0] wide,
    output fxp_pkg::fxp_t                  result,
    output logic                           overflow
);
    import fxp_pkg::*;

    // value after the low fraction bits are dropped, Q16.8
    logic [PROD_WIDTH-FRAC_BITS-1:0]   kept;
    logic [PROD_WIDTH-2*FRAC_BITS-1:0] int_part;
    logic [FRAC_BITS-1:0]              frac_part;
    logic                              at_top;

    // --------------------
    // rounding
    // --------------------

    always_comb begin
        kept = wide[PROD_WIDTH-1:FRAC_BITS];

        // largest positive Q16.8 would wrap if incremented
        at_top = ~kept[PROD_WIDTH-FRAC_BITS-1] & (&kept[PROD_WIDTH-FRAC_BITS-2:0]);

        if (wide[FRAC_BITS-1] && !at_top) begin
            kept = kept + 1'b1;
        end
    end

    assign {int_part, frac_part} = kept;

    // --------------------
    // saturation
    // --------------------

    // integer part fits in INT_BITS only when all upper bits match its sign
    always_comb begin
        overflow = 1'b0;
        result   = {int_part[INT_BITS-1:0], frac_part};

        if (!int_part[PROD_WIDTH-2*FRAC_BITS-1] &&
            (|int_part[PROD_WIDTH-2*FRAC_BITS-2:INT_BITS-1])) begin
            // positive and too large
            overflow = 1'b1;
            result   = FXP_MAX;
        end else if (int_part[PROD_WIDTH-2*FRAC_BITS-1] &&
                     !(&int_part[PROD_WIDTH-2*FRAC_BITS-2:INT_BITS-1])) begin
            // negative and too small
            overflow = 1'b1;
            result   = FXP_MIN;
        end
    end

endmodule

/* logic/stream_pkg.sv */
// --------------------
// Request and response words of the credit streams.
// Both depths must be powers of two.
// --------------------
package stream_pkg;

    import fxp_pkg::*;

    // queue entries, also the sender's credits after reset
    localparam int QUEUE_DEPTH = 4;

    // result slots granted by the sink after reset
    localparam int OUT_CREDITS = 4;

    // pointer, occupancy and counter widths
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int OCNT_W = $clog2(OUT_CREDITS + 1);

    // one operation, 34 bits
    typedef struct packed {
        alu_op_e op;
        fxp_t    a;
        fxp_t    b;
    } op_req_t;

    // one result, 17 bits
    typedef struct packed {
        fxp_t result;
        logic overflow;
    } op_rsp_t;

endpackage

/* logic/fxp_pkg.sv */
// --------------------
// Q8.8 two's complement format shared by the arithmetic blocks.
// Exact products are carried as Q16.16 before they are resized.
// --------------------
package fxp_pkg;

    // --------------------
    // format widths
    // --------------------

    localparam int INT_BITS  = 8;
    localparam int FRAC_BITS = 8;
    localparam int FXP_WIDTH = INT_BITS + FRAC_BITS;

    // full product of two Q8.8 operands, Q16.16
    localparam int PROD_WIDTH = 2 * FXP_WIDTH;

    // --------------------
    // value type and limits
    // --------------------

    typedef logic signed [FXP_WIDTH-1:0] fxp_t;

    // largest value, just under +128.0
    localparam fxp_t FXP_MAX = 16'h7fff;

    // smallest value, exactly -128.0
    localparam fxp_t FXP_MIN = 16'h8000;

    // --------------------
    // opcodes
    // --------------------

    // code 2'b11 is unused and gives a zero result
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } alu_op_e;

endpackage
